// ==== include/wb_config.svh ====
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// Architectural data width of the core
`define XLEN 64

// Integer register file size
`define NUM_REGS 32

// Bits needed to index the register file
`define REG_AW 5

`endif

// ==== verilog/rv_types_pkg.sv ====
`include "wb_config.svh"

package rv_types_pkg;

    // One data word as seen by the datapath
    typedef logic [`XLEN-1:0] xlen_t;

    // Index into the integer register file
    typedef logic [`REG_AW-1:0] reg_addr_t;

endpackage

// ==== verilog/wb_pkg.sv ====
package wb_pkg;

    import rv_types_pkg::*;

    // Owner of the register file write port in the current cycle
    typedef enum logic [2:0] {
        gnt_none,
        gnt_buf,
        gnt_lsp,
        gnt_md,
        gnt_ip,
        gnt_trap
    } wb_grant_e;

    // Single entry collision buffer, also seen by the read ports
    typedef struct packed {
        logic      valid;
        reg_addr_t dst;
        xlen_t     value;
    } wb_buf_t;

endpackage

// ==== verilog/wb_port_if.sv ====
`timescale 1ns/1ns

// One execution unit's finished instruction on its way to writeback
interface wb_port_if import rv_types_pkg::*; ();

    // Item present from the execution unit
    logic      valid;
    // Writeback stage takes the item this cycle
    logic      ready;
    // Destination register and its new value
    reg_addr_t dst;
    xlen_t     result;

    // Execution unit side
    modport source (
        output valid, dst, result,
        input  ready
    );

    // Arbiter side
    modport sink (
        input  valid, dst, result,
        output ready
    );

endinterface

// ==== verilog/wb_arbiter.sv ====
`timescale 1ns/1ns

module wb_arbiter import rv_types_pkg::*, wb_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    wb_port_if.sink    ip,
    wb_port_if.sink    lsp,
    wb_port_if.sink    md,
    wb_port_if.sink    trap,
    input  logic       ip_wb_en,
    input  logic       ip_hipri,
    input  logic       lsp_wb_en,
    input  logic       trap_wb_en,
    output logic       rf_wen,
    output reg_addr_t  rf_wdst,
    output xlen_t      rf_wdata,
    output wb_buf_t    wb_buf,
    output logic [1:0] instret
);

    wb_grant_e grant;

    // Requests that need the write port
    logic ip_req;
    logic lsp_req;
    logic md_req;
    logic trap_req;

    // Buffer may take a new entry this cycle
    logic buf_room;
    logic buf_ld_lsp;
    logic buf_ld_ip;

    // Completed handshakes this cycle
    logic ip_hs;
    logic lsp_hs;
    logic md_hs;
    logic trap_hs;

    // md has no wb_en, it always writes
    assign ip_req   = ip.valid && ip_wb_en;
    assign lsp_req  = lsp.valid && lsp_wb_en;
    assign md_req   = md.valid;
    assign trap_req = trap.valid && trap_wb_en;

    // Fixed priority: buf, lsp, md, ip, trap
    // hipri lets ip jump past buf, lsp and md
    always_comb begin
        grant = gnt_none;
        if (!ip_hipri && wb_buf.valid) begin
            grant = gnt_buf;
        end else if (!ip_hipri && lsp_req) begin
            grant = gnt_lsp;
        end else if (!ip_hipri && md_req) begin
            grant = gnt_md;
        end else if (ip_req) begin
            grant = gnt_ip;
        end else if (trap_req) begin
            grant = gnt_trap;
        end
    end

    // Empty, or drained onto the port this cycle
    assign buf_room   = !wb_buf.valid || (grant == gnt_buf);
    // Losing lsp write has first claim on the buffer
    assign buf_ld_lsp = lsp_req && (grant != gnt_lsp) && buf_room;
    assign buf_ld_ip  = ip_req && (grant != gnt_ip) && !buf_ld_lsp && buf_room;

    // Winner onto the register file write port
    always_comb begin
        rf_wdst  = '0;
        rf_wdata = '0;
        case (grant)
            gnt_buf: begin
                rf_wdst  = wb_buf.dst;
                rf_wdata = wb_buf.value;
            end
            gnt_lsp: begin
                rf_wdst  = lsp.dst;
                rf_wdata = lsp.result;
            end
            gnt_md: begin
                rf_wdst  = md.dst;
                rf_wdata = md.result;
            end
            gnt_ip: begin
                rf_wdst  = ip.dst;
                rf_wdata = ip.result;
            end
            gnt_trap: begin
                rf_wdst  = trap.dst;
                rf_wdata = trap.result;
            end
            default: begin
                rf_wdst  = '0;
                rf_wdata = '0;
            end
        endcase
    end

    assign rf_wen = (grant != gnt_none);

    // Retire without write is always taken
    // md and trap are never buffered, so they wait for the port
    assign ip.ready   = !ip.valid || !ip_wb_en || (grant == gnt_ip) || buf_ld_ip;
    assign lsp.ready  = !lsp.valid || !lsp_wb_en || (grant == gnt_lsp) || buf_ld_lsp;
    assign md.ready   = !md.valid || (grant == gnt_md);
    assign trap.ready = !trap.valid || !trap_wb_en || (grant == gnt_trap);

    // Collision buffer, a new load wins over the drain
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_buf.valid <= 1'b0;
        end else if (buf_ld_lsp) begin
            wb_buf <= '{valid: 1'b1, dst: lsp.dst, value: lsp.result};
        end else if (buf_ld_ip) begin
            wb_buf <= '{valid: 1'b1, dst: ip.dst, value: ip.result};
        end else if (grant == gnt_buf) begin
            wb_buf.valid <= 1'b0;
        end
    end

    assign ip_hs   = ip.valid && ip.ready;
    assign lsp_hs  = lsp.valid && lsp.ready;
    assign md_hs   = md.valid && md.ready;
    assign trap_hs = trap.valid && trap.ready;

    // Retire count one cycle behind the handshakes, wraps at four
    always_ff @(posedge clk) begin
        if (rst) begin
            instret <= 2'd0;
        end else begin
            instret <= 2'(ip_hs) + 2'(lsp_hs) + 2'(md_hs) + 2'(trap_hs);
        end
    end

    // A held entry that is not drained survives to the next cycle untouched
    a_buf_hold: assert property (@(posedge clk) disable iff (rst)
        wb_buf.valid && (grant != gnt_buf) |=> wb_buf.valid && $stable(wb_buf))
        else $error("collision buffer overwritten while still pending");

    // Unbuffered sources are only taken while they own the write port
    a_md_stall: assert property (@(posedge clk) disable iff (rst)
        md.valid && md.ready
        |-> rf_wen && (rf_wdst == md.dst) && (rf_wdata == md.result))
        else $error("md accepted without a grant");

    a_trap_stall: assert property (@(posedge clk) disable iff (rst)
        trap.valid && trap_wb_en && trap.ready
        |-> rf_wen && (rf_wdst == trap.dst) && (rf_wdata == trap.result))
        else $error("trap write accepted without a grant");

    // Port in use whenever some write is allowed to go
    a_wen_grant: assert property (@(posedge clk) disable iff (rst)
        rf_wen == (ip_req || trap_req ||
                   (!ip_hipri && (wb_buf.valid || lsp_req || md_req))))
        else $error("rf_wen disagrees with grant %s", grant.name());

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns
`include "wb_config.svh"

module reg_file import rv_types_pkg::*, wb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      wen,
    input  reg_addr_t wdst,
    input  xlen_t     wdata,
    input  wb_buf_t   fwd_buf,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output xlen_t     rd_data_a,
    output xlen_t     rd_data_b
);

    xlen_t regs [`NUM_REGS];

    // x0 is never written, so its slot stays at the reset value
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wdst != '0)) begin
            regs[wdst] <= wdata;
        end
    end

    // Newest value first: write in flight, then pending buffer, then array
    function automatic xlen_t read_port(input reg_addr_t addr);
        xlen_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wen && (wdst == addr)) begin
            data = wdata;
        end else if (fwd_buf.valid && (fwd_buf.dst == addr)) begin
            data = fwd_buf.value;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

    // A write aimed at x0 leaves no trace in the array
    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        wen && (wdst == '0) |=> regs[0] == '0)
        else $error("x0 picked up a non-zero value");

endmodule

// ==== verilog/retire_counter.sv ====
`timescale 1ns/1ns

module retire_counter import rv_types_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] instret,
    output xlen_t      minstret
);

    xlen_t count;

    // Accumulate the per-cycle retire count
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count + xlen_t'(instret);
        end
    end

    assign minstret = count;

endmodule

// ==== verilog/wb_top.sv ====
`timescale 1ns/1ns

module wb_top import rv_types_pkg::*, wb_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // Integer pipe
    input  logic      ip_valid,
    input  reg_addr_t ip_dst,
    input  xlen_t     ip_result,
    input  logic      ip_wb_en,
    input  logic      ip_hipri,
    output logic      ip_ready,
    // Load-store pipe
    input  logic      lsp_valid,
    input  reg_addr_t lsp_dst,
    input  xlen_t     lsp_result,
    input  logic      lsp_wb_en,
    output logic      lsp_ready,
    // Mul/div unit
    input  logic      md_valid,
    input  reg_addr_t md_dst,
    input  xlen_t     md_result,
    output logic      md_ready,
    // Trap unit
    input  logic      trap_valid,
    input  reg_addr_t trap_dst,
    input  xlen_t     trap_result,
    input  logic      trap_wb_en,
    output logic      trap_ready,
    // Register read ports
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output xlen_t     rd_data_a,
    output xlen_t     rd_data_b,
    // Retired instruction count
    output xlen_t     minstret
);

    wb_port_if ip_port ();
    wb_port_if lsp_port ();
    wb_port_if md_port ();
    wb_port_if trap_port ();

    logic       rf_wen;
    reg_addr_t  rf_wdst;
    xlen_t      rf_wdata;
    wb_buf_t    wb_buf;
    logic [1:0] instret;

    // Bundle the plain ports per source
    assign ip_port.valid    = ip_valid;
    assign ip_port.dst      = ip_dst;
    assign ip_port.result   = ip_result;
    assign ip_ready         = ip_port.ready;

    assign lsp_port.valid   = lsp_valid;
    assign lsp_port.dst     = lsp_dst;
    assign lsp_port.result  = lsp_result;
    assign lsp_ready        = lsp_port.ready;

    assign md_port.valid    = md_valid;
    assign md_port.dst      = md_dst;
    assign md_port.result   = md_result;
    assign md_ready         = md_port.ready;

    assign trap_port.valid  = trap_valid;
    assign trap_port.dst    = trap_dst;
    assign trap_port.result = trap_result;
    assign trap_ready       = trap_port.ready;

    wb_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .ip         (ip_port.sink),
        .lsp        (lsp_port.sink),
        .md         (md_port.sink),
        .trap       (trap_port.sink),
        .ip_wb_en   (ip_wb_en),
        .ip_hipri   (ip_hipri),
        .lsp_wb_en  (lsp_wb_en),
        .trap_wb_en (trap_wb_en),
        .rf_wen     (rf_wen),
        .rf_wdst    (rf_wdst),
        .rf_wdata   (rf_wdata),
        .wb_buf     (wb_buf),
        .instret    (instret)
    );

    // Read ports see both the write in progress and the pending buffer entry
    reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .wen       (rf_wen),
        .wdst      (rf_wdst),
        .wdata     (rf_wdata),
        .fwd_buf   (wb_buf),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    retire_counter u_retire_counter (
        .clk      (clk),
        .rst      (rst),
        .instret  (instret),
        .minstret (minstret)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    // Free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset held for a few rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== test/wb_tb.sv ====
`timescale 1ns/1ns
`include "wb_config.svh"

module wb_tb import rv_types_pkg::*; ();

    localparam int IP = 0;
    localparam int LSP = 1;
    localparam int MD = 2;
    localparam int TRAP = 3;
    localparam int RAND_CYCLES = 400;
    // Directed part, random part, drain and register sweep
    localparam int TEST_CYCLES = 600;

    logic clk;
    logic rst;

    // Source side, indexed by IP, LSP, MD, TRAP
    logic [3:0] src_valid;
    logic [3:0] src_wb_en;
    wire  [3:0] src_ready;
    reg_addr_t  src_dst [4];
    xlen_t      src_result [4];
    logic       ip_hipri;
    reg_addr_t  rd_addr_a;
    reg_addr_t  rd_addr_b;
    xlen_t      rd_data_a;
    xlen_t      rd_data_b;
    xlen_t      minstret;

    // Shadow model
    xlen_t      shadow [`NUM_REGS];
    xlen_t      hs_count;
    xlen_t      hs_count_d;
    logic [3:0] last_hs;
    int         n_hs;
    logic       busy_a;
    logic       busy_b;
    xlen_t      exp_a;
    xlen_t      exp_b;

    // Directed expectations
    logic       fwd_chk;
    xlen_t      fwd_val;
    logic       expect_both;

    tb_clk_gen #(.PERIOD(20), .RST_CYCLES(3)) u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    wb_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .ip_valid    (src_valid[IP]),
        .ip_dst      (src_dst[IP]),
        .ip_result   (src_result[IP]),
        .ip_wb_en    (src_wb_en[IP]),
        .ip_hipri    (ip_hipri),
        .ip_ready    (src_ready[IP]),
        .lsp_valid   (src_valid[LSP]),
        .lsp_dst     (src_dst[LSP]),
        .lsp_result  (src_result[LSP]),
        .lsp_wb_en   (src_wb_en[LSP]),
        .lsp_ready   (src_ready[LSP]),
        .md_valid    (src_valid[MD]),
        .md_dst      (src_dst[MD]),
        .md_result   (src_result[MD]),
        .md_ready    (src_ready[MD]),
        .trap_valid  (src_valid[TRAP]),
        .trap_dst    (src_dst[TRAP]),
        .trap_result (src_result[TRAP]),
        .trap_wb_en  (src_wb_en[TRAP]),
        .trap_ready  (src_ready[TRAP]),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .minstret    (minstret)
    );

    // Handshakes and pending writes in the current cycle
    always_comb begin
        n_hs = 0;
        busy_a = 1'b0;
        busy_b = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (src_valid[i] && src_ready[i]) begin
                n_hs = n_hs + 1;
            end
            // A write still on its way makes that register unpredictable
            if (src_valid[i] && src_wb_en[i] && (src_dst[i] != '0)) begin
                if (src_dst[i] == rd_addr_a) begin
                    busy_a = 1'b1;
                end
                if (src_dst[i] == rd_addr_b) begin
                    busy_b = 1'b1;
                end
            end
        end
    end

    assign exp_a = shadow[rd_addr_a];
    assign exp_b = shadow[rd_addr_b];

    // Register image after all accepted writes, plus retire count
    always @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                shadow[r] <= '0;
            end
            hs_count <= '0;
            hs_count_d <= '0;
            last_hs <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (src_valid[i] && src_ready[i] && src_wb_en[i] && (src_dst[i] != '0)) begin
                    shadow[src_dst[i]] <= src_result[i];
                end
            end
            last_hs <= src_valid & src_ready;
            hs_count <= hs_count + xlen_t'(n_hs);
            // minstret trails the handshakes by two edges
            hs_count_d <= hs_count;
        end
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    a_rd_a: assert property (@(posedge clk) disable iff (rst) !busy_a |-> rd_data_a == exp_a)
        else begin
            $display("FAIL %0t ns rd_data_a expected %h actual %h",
                $time, $sampled(exp_a), $sampled(rd_data_a));
            abort_run();
        end

    a_rd_b: assert property (@(posedge clk) disable iff (rst) !busy_b |-> rd_data_b == exp_b)
        else begin
            $display("FAIL %0t ns rd_data_b expected %h actual %h",
                $time, $sampled(exp_b), $sampled(rd_data_b));
            abort_run();
        end

    a_minstret: assert property (@(posedge clk) disable iff (rst) minstret == hs_count_d)
        else begin
            $display("FAIL %0t ns minstret expected %0d actual %0d",
                $time, $sampled(hs_count_d), $sampled(minstret));
            abort_run();
        end

    // Idle sources always see ready
    a_idle_ready: assert property (@(posedge clk) disable iff (rst)
        (src_ready | src_valid) == 4'hf)
        else begin
            $display("FAIL %0t ns src_ready expected %b actual %b",
                $time, $sampled(src_ready | ~src_valid), $sampled(src_ready));
            abort_run();
        end

    // Single write with an idle buffer is forwarded in its own cycle
    a_fwd: assert property (@(posedge clk) disable iff (rst) fwd_chk |-> rd_data_a == fwd_val)
        else begin
            $display("FAIL %0t ns rd_data_a expected %h actual %h",
                $time, $sampled(fwd_val), $sampled(rd_data_a));
            abort_run();
        end

    a_both: assert property (@(posedge clk) disable iff (rst)
        expect_both |-> src_ready[IP] && src_ready[LSP])
        else begin
            $display("FAIL %0t ns ip_ready,lsp_ready expected 11 actual %b%b",
                $time, $sampled(src_ready[IP]), $sampled(src_ready[LSP]));
            abort_run();
        end

    a_hipri: assert property (@(posedge clk) disable iff (rst)
        ip_hipri && src_valid[IP] |-> src_ready[IP])
        else begin
            $display("FAIL %0t ns ip_ready expected 1 actual 0", $time);
            abort_run();
        end

    // md loses to a writing lsp unless ip has priority
    a_md_wait: assert property (@(posedge clk) disable iff (rst)
        src_valid[MD] && src_valid[LSP] && src_wb_en[LSP] && !ip_hipri |-> !src_ready[MD])
        else begin
            $display("FAIL %0t ns md_ready expected 0 actual 1", $time);
            abort_run();
        end

    a_trap_wait: assert property (@(posedge clk) disable iff (rst)
        src_valid[TRAP] && src_wb_en[TRAP] && ((src_valid[IP] && src_wb_en[IP]) ||
        (!ip_hipri && ((src_valid[LSP] && src_wb_en[LSP]) || src_valid[MD])))
        |-> !src_ready[TRAP])
        else begin
            $display("FAIL %0t ns trap_ready expected 0 actual 1", $time);
            abort_run();
        end

    // Watchdog
    initial begin
        #(TEST_CYCLES * 20 * 4);
        $display("Timeout: the run did not finish within %0d ns", TEST_CYCLES * 20 * 4);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    function automatic xlen_t rand_word();
        return xlen_t'({$urandom, $urandom});
    endfunction

    function automatic logic dst_in_use(input reg_addr_t dst);
        logic used;
        used = 1'b0;
        for (int i = 0; i < 4; i++) begin
            if (src_valid[i] && (src_dst[i] == dst)) begin
                used = 1'b1;
            end
        end
        return used;
    endfunction

    // Caller sits on a falling edge; md always writes
    task automatic present_item(input int i, input reg_addr_t dst, input xlen_t val,
                                input logic en);
        src_valid[i] = 1'b1;
        src_dst[i] = dst;
        src_result[i] = val;
        src_wb_en[i] = (i == MD) ? 1'b1 : en;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Hold each item until its handshake, then drop it
    task automatic drain_sources();
        do begin
            @(negedge clk);
            src_valid = src_valid & ~last_hs;
            if (last_hs[IP]) begin
                ip_hipri = 1'b0;
            end
            fwd_chk = 1'b0;
            expect_both = 1'b0;
        end while (src_valid != '0);
    endtask

    // One falling edge of random traffic, at most three sources busy
    task automatic random_cycle();
        int n_valid;
        reg_addr_t dst;
        src_valid = src_valid & ~last_hs;
        n_valid = $countones(src_valid);
        for (int i = 0; i < 4; i++) begin
            if (!src_valid[i] && (n_valid < 3) && ($urandom_range(1) == 1)) begin
                do begin
                    dst = reg_addr_t'($urandom_range(`NUM_REGS - 1));
                end while (dst_in_use(dst));
                present_item(i, dst, rand_word(), $urandom_range(3) != 0);
                n_valid = n_valid + 1;
            end
        end
        rd_addr_a = reg_addr_t'($urandom_range(`NUM_REGS - 1));
        rd_addr_b = reg_addr_t'($urandom_range(`NUM_REGS - 1));
    endtask

    initial begin
        xlen_t val;
        void'($urandom(32'h5ad7_7d87));
        src_valid = '0;
        src_wb_en = '1;
        for (int i = 0; i < 4; i++) begin
            src_dst[i] = '0;
            src_result[i] = '0;
        end
        ip_hipri = 1'b0;
        rd_addr_a = reg_addr_t'(1);
        rd_addr_b = reg_addr_t'(2);
        fwd_chk = 1'b0;
        fwd_val = '0;
        expect_both = 1'b0;
        wait (!rst);
        idle(3);

        // Each unit alone goes straight onto the write port
        for (int i = 0; i < 4; i++) begin
            val = rand_word();
            present_item(i, reg_addr_t'(i + 1), val, 1'b1);
            rd_addr_a = reg_addr_t'(i + 1);
            fwd_val = val;
            fwd_chk = 1'b1;
            drain_sources();
            idle(2);
        end

        // Retirements without a write, and a write to x0
        rd_addr_a = reg_addr_t'(1);
        rd_addr_b = reg_addr_t'(2);
        present_item(IP, reg_addr_t'(1), rand_word(), 1'b0);
        present_item(LSP, reg_addr_t'(2), rand_word(), 1'b0);
        present_item(TRAP, reg_addr_t'(4), rand_word(), 1'b0);
        drain_sources();
        rd_addr_a = '0;
        present_item(MD, '0, rand_word(), 1'b1);
        drain_sources();
        idle(2);

        // lsp direct and ip into the buffer in one cycle
        present_item(LSP, reg_addr_t'(10), rand_word(), 1'b1);
        present_item(IP, reg_addr_t'(11), rand_word(), 1'b1);
        rd_addr_a = reg_addr_t'(11);
        rd_addr_b = reg_addr_t'(10);
        expect_both = 1'b1;
        drain_sources();
        idle(3);

        // ip jumps ahead of held lsp and md
        present_item(LSP, reg_addr_t'(12), rand_word(), 1'b1);
        present_item(MD, reg_addr_t'(13), rand_word(), 1'b1);
        present_item(IP, reg_addr_t'(14), rand_word(), 1'b1);
        ip_hipri = 1'b1;
        rd_addr_a = reg_addr_t'(12);
        rd_addr_b = reg_addr_t'(13);
        drain_sources();
        idle(3);

        // md and trap stall behind lsp
        present_item(LSP, reg_addr_t'(15), rand_word(), 1'b1);
        present_item(MD, reg_addr_t'(16), rand_word(), 1'b1);
        present_item(TRAP, reg_addr_t'(17), rand_word(), 1'b1);
        rd_addr_a = reg_addr_t'(16);
        rd_addr_b = reg_addr_t'(17);
        drain_sources();
        idle(3);

        // Random traffic without hipri, then a full register sweep
        repeat (RAND_CYCLES) begin
            @(negedge clk);
            random_cycle();
        end
        drain_sources();
        idle(3);
        for (int r = 0; r < `NUM_REGS; r++) begin
            rd_addr_a = reg_addr_t'(r);
            rd_addr_b = reg_addr_t'(`NUM_REGS - 1 - r);
            @(negedge clk);
        end
        idle(2);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
verilog/rv_types_pkg.sv
verilog/wb_pkg.sv
verilog/wb_port_if.sv
verilog/wb_arbiter.sv
verilog/reg_file.sv
verilog/retire_counter.sv
verilog/wb_top.sv
test/tb_clk_gen.sv
test/wb_tb.sv

// ==== Bender.yml ====
package:
  name: wb_stage

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv_types_pkg.sv
      - verilog/wb_pkg.sv
      - verilog/wb_port_if.sv
      - verilog/wb_arbiter.sv
      - verilog/reg_file.sv
      - verilog/retire_counter.sv
      - verilog/wb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_clk_gen.sv
      - test/wb_tb.sv
